//--- compile.f
+incdir+include
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/reorder_buffer.sv
logic/retire_status.sv
logic/rename_core.sv
verif/rename_core_tb.sv

//--- logic/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic    [num_super-1:0]    pop,
  input  logic    [num_super-1:0]    push,
  input  pr_tag_t [num_super-1:0]    push_tag,
  output pr_tag_t [num_super-1:0]    alloc_tag,
  output logic                       has_two
);

  pr_tag_t fifo [num_fl];
  fl_idx_t head;
  fl_idx_t tail;
  fl_cnt_t count;
  fl_cnt_t num_pop;
  fl_cnt_t num_push;

  assign num_pop  = fl_cnt_t'(pop[0]) + fl_cnt_t'(pop[1]);
  assign num_push = fl_cnt_t'(push[0]) + fl_cnt_t'(push[1]);
  assign has_two  = count >= fl_cnt_t'(2);

  // Slot 1 takes the second entry only when slot 0 consumes the head
  assign alloc_tag[0] = fifo[head];
  assign alloc_tag[1] = pop[0] ? fifo[head + fl_idx_t'(1)] : fifo[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;                  // Full list, tail wraps onto head
      count <= fl_cnt_t'(num_fl);
      for (int i = 0; i < num_fl; i++) begin
        fifo[i] <= pr_tag_t'(num_arch + i);
      end
    end else begin
      if (push[0]) begin
        fifo[tail] <= push_tag[0];
      end
      if (push[1]) begin
        fifo[tail + fl_idx_t'(push[0])] <= push_tag[1];
      end
      head  <= head + fl_idx_t'(num_pop);
      tail  <= tail + fl_idx_t'(num_push);
      count <= count - num_pop + num_push;
    end
  end

  // Dispatch gating upstream must keep pops within the stock
  assert property (@(posedge clock) disable iff (reset)
    num_pop <= count)
  else $error("free_list: pop of %0d with %0d tags left", num_pop, count);

  // Retirement returns only tags that were handed out
  assert property (@(posedge clock) disable iff (reset)
    int'(count) - int'(num_pop) + int'(num_push) <= num_fl)
  else $error("free_list: push overflows, count %0d", count);

endmodule

//--- logic/map_table.sv
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic      [num_super-1:0]    write_en,
  input  arch_idx_t [num_super-1:0]    write_dest,
  input  pr_tag_t   [num_super-1:0]    write_tag,
  input  arch_idx_t [num_super-1:0]    read_dest,
  output pr_tag_t   [num_super-1:0]    told
);

  pr_tag_t map [num_arch];
  logic    bypass;

  // Slot 1 renaming the register slot 0 just renamed
  assign bypass  = write_en[0] && (write_dest[0] == read_dest[1]);

  assign told[0] = map[read_dest[0]];
  assign told[1] = bypass ? write_tag[0] : map[read_dest[1]];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_arch; r++) begin
        map[r] <= pr_tag_t'(r);     // Identity mapping
      end
    end else begin
      if (write_en[0]) begin
        map[write_dest[0]] <= write_tag[0];
      end
      if (write_en[1]) begin
        map[write_dest[1]] <= write_tag[1];   // Younger slot wins
      end
    end
  end

  // The top must filter zero_reg before it reaches the table
  assert property (@(posedge clock) disable iff (reset)
    !(write_en[0] && write_dest[0] == arch_idx_t'(zero_reg)) &&
    !(write_en[1] && write_dest[1] == arch_idx_t'(zero_reg)))
  else $error("map_table: write to zero_reg");

endmodule

//--- logic/rename_core.sv
`timescale 1ns/1ps

module rename_core import rename_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic      [num_super-1:0]    dispatch_valid,
  input  arch_idx_t [num_super-1:0]    dispatch_dest,
  input  logic      [num_super-1:0]    dispatch_halt,
  input  logic      [num_super-1:0]    dispatch_illegal,
  input  logic      [num_super-1:0]    complete_valid,
  input  rob_idx_t  [num_super-1:0]    complete_rob_idx,
  output logic                         dispatch_ready,
  output pr_tag_t   [num_super-1:0]    dispatch_tag,
  output pr_tag_t   [num_super-1:0]    dispatch_told,
  output rob_idx_t  [num_super-1:0]    dispatch_rob_idx,
  output logic      [num_super-1:0]    pipeline_commit_wr_en,
  output arch_idx_t [num_super-1:0]    pipeline_commit_wr_idx,
  output pr_tag_t   [num_super-1:0]    pipeline_commit_tag,
  output pr_tag_t   [num_super-1:0]    pipeline_commit_told,
  output logic      [num_super-1:0]    retire_valid,
  output logic      [3:0]              pipeline_completed_insts,
  output error_code_t                  pipeline_error_status,
  output logic                         stop_cycle
);

  logic    [num_super-1:0] dispatch_en;
  logic    [num_super-1:0] needs_tag;
  logic    [num_super-1:0] fl_pop;
  pr_tag_t [num_super-1:0] alloc_tag;
  logic                    fl_has_two;
  logic                    rob_has_two_free;
  logic    [num_super-1:0] retire_halt;
  logic    [num_super-1:0] retire_illegal;

  assign dispatch_ready = rob_has_two_free && fl_has_two && !stop_cycle;
  assign dispatch_en    = dispatch_valid & {num_super{dispatch_ready}};
  assign fl_pop         = dispatch_en & needs_tag;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      needs_tag[i]    = dispatch_dest[i] != arch_idx_t'(zero_reg);
      dispatch_tag[i] = needs_tag[i] ? alloc_tag[i] : '0;
      // Only real destinations commit and recycle their old tag
      pipeline_commit_wr_en[i] = retire_valid[i] &&
                                 (pipeline_commit_wr_idx[i] != arch_idx_t'(zero_reg));
    end
  end

  free_list free_list_i (
    .clock     (clock),
    .reset     (reset),
    .pop       (fl_pop),
    .push      (pipeline_commit_wr_en),
    .push_tag  (pipeline_commit_told),
    .alloc_tag (alloc_tag),
    .has_two   (fl_has_two)
  );

  map_table map_table_i (
    .clock      (clock),
    .reset      (reset),
    .write_en   (fl_pop),
    .write_dest (dispatch_dest),
    .write_tag  (alloc_tag),
    .read_dest  (dispatch_dest),
    .told       (dispatch_told)
  );

  reorder_buffer reorder_buffer_i (
    .clock            (clock),
    .reset            (reset),
    .dispatch_en      (dispatch_en),
    .dispatch_dest    (dispatch_dest),
    .dispatch_tag     (dispatch_tag),
    .dispatch_told    (dispatch_told),
    .dispatch_halt    (dispatch_halt),
    .dispatch_illegal (dispatch_illegal),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .stop             (stop_cycle),
    .has_two_free     (rob_has_two_free),
    .dispatch_rob_idx (dispatch_rob_idx),
    .retire_valid     (retire_valid),
    .retire_dest      (pipeline_commit_wr_idx),
    .retire_tag       (pipeline_commit_tag),
    .retire_told      (pipeline_commit_told),
    .retire_halt      (retire_halt),
    .retire_illegal   (retire_illegal)
  );

  retire_status retire_status_i (
    .clock                    (clock),
    .reset                    (reset),
    .retire_valid             (retire_valid),
    .retire_halt              (retire_halt),
    .retire_illegal           (retire_illegal),
    .stop_cycle               (stop_cycle),
    .pipeline_completed_insts (pipeline_completed_insts),
    .pipeline_error_status    (pipeline_error_status)
  );

endmodule

//--- logic/rename_pkg.sv
package rename_pkg;

  localparam int num_super = 2;   // Dispatch and retire width
  localparam int num_arch  = 32;
  localparam int zero_reg  = 31;  // Never renamed, never committed
  localparam int num_pr    = 64;
  localparam int num_fl    = num_pr - num_arch;
  localparam int num_rob   = 16;

  typedef logic [$clog2(num_arch)-1:0] arch_idx_t;
  typedef logic [$clog2(num_pr)-1:0]   pr_tag_t;
  typedef logic [$clog2(num_rob)-1:0]  rob_idx_t;

  // Pointers wrap by overflow, counts reach the full depth
  typedef logic [$clog2(num_fl)-1:0]    fl_idx_t;
  typedef logic [$clog2(num_fl+1)-1:0]  fl_cnt_t;
  typedef logic [$clog2(num_rob+1)-1:0] rob_cnt_t;

  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_code_t;

endpackage

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic      [num_super-1:0]    dispatch_en,
  input  arch_idx_t [num_super-1:0]    dispatch_dest,
  input  pr_tag_t   [num_super-1:0]    dispatch_tag,
  input  pr_tag_t   [num_super-1:0]    dispatch_told,
  input  logic      [num_super-1:0]    dispatch_halt,
  input  logic      [num_super-1:0]    dispatch_illegal,
  input  logic      [num_super-1:0]    complete_valid,
  input  rob_idx_t  [num_super-1:0]    complete_rob_idx,
  input  logic                         stop,
  output logic                         has_two_free,
  output rob_idx_t  [num_super-1:0]    dispatch_rob_idx,
  output logic      [num_super-1:0]    retire_valid,
  output arch_idx_t [num_super-1:0]    retire_dest,
  output pr_tag_t   [num_super-1:0]    retire_tag,
  output pr_tag_t   [num_super-1:0]    retire_told,
  output logic      [num_super-1:0]    retire_halt,
  output logic      [num_super-1:0]    retire_illegal
);

  arch_idx_t              rob_dest    [num_rob];
  pr_tag_t                rob_tag     [num_rob];
  pr_tag_t                rob_told    [num_rob];
  logic                   rob_halt    [num_rob];
  logic                   rob_illegal [num_rob];
  logic     [num_rob-1:0] rob_valid;
  logic     [num_rob-1:0] rob_done;

  rob_idx_t                  head;
  rob_idx_t                  tail;
  rob_cnt_t                  count;
  rob_cnt_t                  num_disp;
  rob_cnt_t                  num_ret;
  rob_idx_t [num_super-1:0]  retire_idx;
  logic                      head_stops;

  assign has_two_free = count <= rob_cnt_t'(num_rob - 2);
  assign num_disp     = rob_cnt_t'(dispatch_en[0]) + rob_cnt_t'(dispatch_en[1]);
  assign num_ret      = rob_cnt_t'(retire_valid[0]) + rob_cnt_t'(retire_valid[1]);

  assign dispatch_rob_idx[0] = tail;
  assign dispatch_rob_idx[1] = tail + rob_idx_t'(dispatch_en[0]);

  assign retire_idx[0] = head;
  assign retire_idx[1] = head + rob_idx_t'(1);

  // A halt or illegal entry retires alone
  assign head_stops = rob_halt[head] || rob_illegal[head];

  assign retire_valid[0] = !stop && rob_valid[head] && rob_done[head];
  assign retire_valid[1] = retire_valid[0] && !head_stops &&
                           rob_valid[retire_idx[1]] && rob_done[retire_idx[1]];

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      retire_dest[i]    = rob_dest[retire_idx[i]];
      retire_tag[i]     = rob_tag[retire_idx[i]];
      retire_told[i]    = rob_told[retire_idx[i]];
      retire_halt[i]    = retire_valid[i] && rob_halt[retire_idx[i]];
      retire_illegal[i] = retire_valid[i] && rob_illegal[retire_idx[i]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      rob_valid <= '0;
      rob_done  <= '0;
    end else begin
      for (int i = 0; i < num_super; i++) begin
        if (retire_valid[i]) begin
          rob_valid[retire_idx[i]] <= 1'b0;
        end
      end
      for (int i = 0; i < num_super; i++) begin
        if (complete_valid[i]) begin
          rob_done[complete_rob_idx[i]] <= 1'b1;
        end
      end
      // Room check keeps new entries off any retiring slot
      for (int i = 0; i < num_super; i++) begin
        if (dispatch_en[i]) begin
          rob_valid[dispatch_rob_idx[i]] <= 1'b1;
          rob_done[dispatch_rob_idx[i]]  <= 1'b0;
        end
      end
      head  <= head + rob_idx_t'(num_ret);
      tail  <= tail + rob_idx_t'(num_disp);
      count <= count + num_disp - num_ret;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_super; i++) begin
      if (dispatch_en[i]) begin
        rob_dest[dispatch_rob_idx[i]]    <= dispatch_dest[i];
        rob_tag[dispatch_rob_idx[i]]     <= dispatch_tag[i];
        rob_told[dispatch_rob_idx[i]]    <= dispatch_told[i];
        rob_halt[dispatch_rob_idx[i]]    <= dispatch_halt[i];
        rob_illegal[dispatch_rob_idx[i]] <= dispatch_illegal[i];
      end
    end
  end

  // Completion must name something still in flight
  for (genvar i = 0; i < num_super; i++) begin : g_complete_chk
    assert property (@(posedge clock) disable iff (reset)
      complete_valid[i] |-> rob_valid[complete_rob_idx[i]])
    else $error("reorder_buffer: completion of empty entry %0d", complete_rob_idx[i]);
  end

endmodule

//--- logic/retire_status.sv
`timescale 1ns/1ps

module retire_status import rename_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [num_super-1:0]    retire_valid,
  input  logic [num_super-1:0]    retire_halt,
  input  logic [num_super-1:0]    retire_illegal,
  output logic                    stop_cycle,
  output logic [3:0]              pipeline_completed_insts,
  output error_code_t             pipeline_error_status
);

  logic        stop_event;
  error_code_t stop_code;

  // Halting entries count as completed
  assign pipeline_completed_insts = 4'(retire_valid[0]) + 4'(retire_valid[1]);

  assign stop_event = |(retire_halt | retire_illegal);

  // Slot 0 decides first, slot 1 only retires behind a plain entry
  assign stop_code = retire_halt[0]    ? halted_on_halt :
                     retire_illegal[0] ? halted_on_illegal :
                     retire_halt[1]    ? halted_on_halt : halted_on_illegal;

  always_ff @(posedge clock) begin
    if (reset) begin
      stop_cycle            <= 1'b0;
      pipeline_error_status <= no_error;
    end else if (stop_event && !stop_cycle) begin
      stop_cycle            <= 1'b1;
      pipeline_error_status <= stop_code;
    end
  end

  // Once stopped the ROB must stay frozen
  assert property (@(posedge clock) disable iff (reset)
    stop_cycle |-> retire_valid == '0)
  else $error("retire_status: retirement after stop");

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module rename_core_tb -o rename_core_sim

output=$(./obj_dir/rename_core_sim)
echo "$output"
grep -q "Result: PASSED" <<< "$output"

//--- include/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct {
  arch_idx_t dest;
  pr_tag_t   tag;
  pr_tag_t   told;
  logic      halt;
  logic      illegal;
} model_entry_t;

pr_tag_t      model_free_q [$];
pr_tag_t      model_map    [num_arch];
model_entry_t model_rob_q  [$];

function automatic void model_reset();
  model_free_q.delete();
  model_rob_q.delete();
  for (int i = 0; i < num_fl; i++) begin
    model_free_q.push_back(pr_tag_t'(num_arch + i));
  end
  for (int r = 0; r < num_arch; r++) begin
    model_map[r] = pr_tag_t'(r);
  end
endfunction

// Call slot 0 before slot 1 so the in-group bypass falls out naturally
function automatic void model_dispatch(input arch_idx_t dest, input logic halt,
                                       input logic illegal, output pr_tag_t tag,
                                       output pr_tag_t told);
  model_entry_t entry;
  told = model_map[dest];
  tag  = '0;                        // zero_reg reports tag 0
  if (dest != arch_idx_t'(zero_reg)) begin
    tag = model_free_q.pop_front();
    model_map[dest] = tag;
  end
  entry.dest    = dest;
  entry.tag     = tag;
  entry.told    = told;
  entry.halt    = halt;
  entry.illegal = illegal;
  model_rob_q.push_back(entry);
endfunction

// Oldest entry leaves, its old tag goes to the back of the free list
function automatic model_entry_t model_retire();
  model_entry_t entry;
  entry = model_rob_q.pop_front();
  if (entry.dest != arch_idx_t'(zero_reg)) begin
    model_free_q.push_back(entry.told);
  end
  return entry;
endfunction

function automatic logic model_wr_en(input model_entry_t entry);
  return entry.dest != arch_idx_t'(zero_reg);
endfunction

function automatic int model_in_flight();
  return model_rob_q.size();
endfunction

`endif

//--- verif/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb import rename_pkg::*;;

  logic                         clock;
  logic                         reset;
  logic      [num_super-1:0]    dispatch_valid;
  arch_idx_t [num_super-1:0]    dispatch_dest;
  logic      [num_super-1:0]    dispatch_halt;
  logic      [num_super-1:0]    dispatch_illegal;
  logic      [num_super-1:0]    complete_valid;
  rob_idx_t  [num_super-1:0]    complete_rob_idx;
  logic                         dispatch_ready;
  pr_tag_t   [num_super-1:0]    dispatch_tag;
  pr_tag_t   [num_super-1:0]    dispatch_told;
  rob_idx_t  [num_super-1:0]    dispatch_rob_idx;
  logic      [num_super-1:0]    pipeline_commit_wr_en;
  arch_idx_t [num_super-1:0]    pipeline_commit_wr_idx;
  pr_tag_t   [num_super-1:0]    pipeline_commit_tag;
  pr_tag_t   [num_super-1:0]    pipeline_commit_told;
  logic      [num_super-1:0]    retire_valid;
  logic      [3:0]              pipeline_completed_insts;
  error_code_t                  pipeline_error_status;
  logic                         stop_cycle;

  `include "rename_model.svh"

  int           seed = 58;
  int           errors;
  int           tests_run;
  int           tests_failed;
  int           errors_at_start;
  bit           timed_out;
  rob_idx_t     pending [$];      // Dispatched, not yet completed
  logic [num_rob-1:0] done;
  rob_idx_t     exp_head;
  rob_idx_t     exp_tail;
  logic         exp_stop;
  error_code_t  exp_status;

  rename_core rename_core_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // Entries at the head that may leave in the current cycle
  function automatic int expected_retire_count();
    int n;
    n = 0;
    if (!exp_stop && model_in_flight() > 0 && done[exp_head]) begin
      n = 1;
      if (!model_rob_q[0].halt && !model_rob_q[0].illegal && model_in_flight() > 1 &&
          done[exp_head + rob_idx_t'(1)]) begin
        n = 2;
      end
    end
    return n;
  endfunction

  always @(negedge clock) begin
    model_entry_t entry;
    int           exp_n;
    logic         exp_ready;
    pr_tag_t      tag;
    pr_tag_t      told;
    if (reset) begin
      model_reset();
      pending.delete();
      done       = '0;
      exp_head   = '0;
      exp_tail   = '0;
      exp_stop   = 1'b0;
      exp_status = no_error;
    end else begin
      exp_ready = (num_rob - model_in_flight() >= 2) && (model_free_q.size() >= 2) && !exp_stop;
      exp_n     = expected_retire_count();
      check_value("dispatch_ready", dispatch_ready, exp_ready);
      check_value("stop_cycle", stop_cycle, exp_stop);
      check_value("pipeline_error_status", pipeline_error_status, exp_status);
      check_value("pipeline_completed_insts", pipeline_completed_insts, exp_n);
      for (int i = 0; i < num_super; i++) begin
        check_value($sformatf("retire_valid[%0d]", i), retire_valid[i], i < exp_n);
        if (i < exp_n) begin
          entry = model_retire();
          check_value($sformatf("pipeline_commit_wr_en[%0d]", i),
                      pipeline_commit_wr_en[i], model_wr_en(entry));
          check_value($sformatf("pipeline_commit_wr_idx[%0d]", i),
                      pipeline_commit_wr_idx[i], entry.dest);
          check_value($sformatf("pipeline_commit_tag[%0d]", i), pipeline_commit_tag[i], entry.tag);
          check_value($sformatf("pipeline_commit_told[%0d]", i),
                      pipeline_commit_told[i], entry.told);
          if (entry.halt || entry.illegal) begin
            exp_stop   = 1'b1;   // Seen from the next cycle on
            exp_status = entry.halt ? halted_on_halt : halted_on_illegal;
          end
        end else begin
          check_value($sformatf("pipeline_commit_wr_en[%0d]", i), pipeline_commit_wr_en[i], 0);
        end
      end
      exp_head = exp_head + rob_idx_t'(exp_n);
      for (int i = 0; i < num_super; i++) begin
        if (complete_valid[i]) begin
          done[complete_rob_idx[i]] = 1'b1;
        end
      end
      for (int i = 0; i < num_super; i++) begin
        if (exp_ready && dispatch_valid[i]) begin
          model_dispatch(dispatch_dest[i], dispatch_halt[i], dispatch_illegal[i], tag, told);
          check_value($sformatf("dispatch_tag[%0d]", i), dispatch_tag[i], tag);
          check_value($sformatf("dispatch_told[%0d]", i), dispatch_told[i], told);
          check_value($sformatf("dispatch_rob_idx[%0d]", i), dispatch_rob_idx[i], exp_tail);
          done[exp_tail] = 1'b0;
          pending.push_back(exp_tail);
          exp_tail++;
        end
      end
    end
  end

  task automatic end_run();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors > errors_at_start) begin
      tests_failed++;
    end
    $display("test %s: %s", name, (errors > errors_at_start) ? "failed" : "ok");
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
    dispatch_valid   = '0;
    dispatch_halt    = '0;
    dispatch_illegal = '0;
    complete_valid   = '0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    next_cycle();
    repeat (9) @(posedge clock);
    #1 reset = 1'b0;
  endtask

  task automatic drive_group(input logic v1, input arch_idx_t d0, input logic h0,
                             input logic i0, input arch_idx_t d1, input logic h1,
                             input logic i1);
    dispatch_valid   = {v1, 1'b1};
    dispatch_dest    = {d1, d0};
    dispatch_halt    = {h1 & v1, h0};
    dispatch_illegal = {i1 & v1, i0};
  endtask

  // Random picks give out of order completion
  task automatic complete_some(input int max_n);
    int pick;
    for (int k = 0; k < max_n && pending.size() > 0; k++) begin
      pick = $unsigned($random(seed)) % pending.size();
      complete_valid[k]   = 1'b1;
      complete_rob_idx[k] = pending[pick];
      pending.delete(pick);
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    for (n = 0; n < limit && model_in_flight() > 0; n++) begin
      next_cycle();
      complete_some(2);
    end
    if (model_in_flight() > 0) begin
      note_timeout("the ROB to drain");
    end
  endtask

  task automatic wait_stopped(input int limit);
    int n;
    for (n = 0; n < limit && !stop_cycle; n++) begin
      next_cycle();
      complete_some(2);
    end
    if (!stop_cycle) begin
      note_timeout("stop_cycle");
    end
  endtask

  function automatic arch_idx_t random_dest(input int range);
    return arch_idx_t'($unsigned($random(seed)) % range);
  endfunction

  task automatic run_tests();
    apply_reset();

    begin_test();
    @(negedge clock);
    check_value("dispatch_ready", dispatch_ready, 1);
    check_value("stop_cycle", stop_cycle, 0);
    check_value("pipeline_commit_wr_en", pipeline_commit_wr_en, 0);
    check_value("retire_valid", retire_valid, 0);
    check_value("pipeline_completed_insts", pipeline_completed_insts, 0);
    check_value("pipeline_error_status", pipeline_error_status, no_error);
    end_test("reset state");

    begin_test();
    next_cycle();
    drive_group(1'b1, 5'd5, 1'b0, 1'b0, 5'd31, 1'b0, 1'b0);
    @(negedge clock);
    check_value("dispatch_tag[0]", dispatch_tag[0], 32);
    check_value("dispatch_told[0]", dispatch_told[0], 5);
    check_value("dispatch_tag[1]", dispatch_tag[1], 0);
    check_value("dispatch_told[1]", dispatch_told[1], 31);
    next_cycle();
    drive_group(1'b1, 5'd7, 1'b0, 1'b0, 5'd7, 1'b0, 1'b0);   // Bypass inside the group
    @(negedge clock);
    check_value("dispatch_tag[0]", dispatch_tag[0], 33);
    check_value("dispatch_told[0]", dispatch_told[0], 7);
    check_value("dispatch_tag[1]", dispatch_tag[1], 34);
    check_value("dispatch_told[1]", dispatch_told[1], 33);
    wait_drained(100);
    if (timed_out) begin
      return;
    end
    end_test("first allocations");

    begin_test();
    for (int g = 0; g < 40; g++) begin
      next_cycle();
      if (dispatch_ready) begin
        drive_group(1'($random(seed) & 1), random_dest(32), 1'b0, 1'b0,
                    random_dest(32), 1'b0, 1'b0);
      end
      complete_some(2);
    end
    wait_drained(200);
    if (timed_out) begin
      return;
    end
    end_test("random out of order completion");

    begin_test();
    for (int g = 0; g < 8; g++) begin
      next_cycle();
      drive_group(1'b1, random_dest(31), 1'b0, 1'b0, random_dest(31), 1'b0, 1'b0);
    end
    next_cycle();
    check_value("dispatch_ready", dispatch_ready, 0);
    for (int g = 0; g < 3; g++) begin
      drive_group(1'b1, random_dest(31), 1'b0, 1'b0, random_dest(31), 1'b0, 1'b0);
      next_cycle();
    end
    wait_drained(200);
    if (timed_out) begin
      return;
    end
    for (int g = 0; g < 8; g++) begin
      next_cycle();
      drive_group(1'b1, random_dest(31), 1'b0, 1'b0, random_dest(31), 1'b0, 1'b0);
    end
    wait_drained(200);
    if (timed_out) begin
      return;
    end
    end_test("full ROB and tag reuse");

    begin_test();
    next_cycle();
    drive_group(1'b1, 5'd31, 1'b1, 1'b0, 5'd9, 1'b0, 1'b0);
    wait_stopped(100);
    if (timed_out) begin
      return;
    end
    check_value("pipeline_error_status", pipeline_error_status, halted_on_halt);
    check_value("dispatch_ready", dispatch_ready, 0);
    for (int g = 0; g < 5; g++) begin
      next_cycle();
      drive_group(1'b1, random_dest(31), 1'b0, 1'b0, random_dest(31), 1'b0, 1'b0);
      complete_some(2);
    end
    apply_reset();
    next_cycle();
    drive_group(1'b1, 5'd4, 1'b0, 1'b0, 5'd31, 1'b0, 1'b1);
    wait_stopped(100);
    if (timed_out) begin
      return;
    end
    check_value("pipeline_error_status", pipeline_error_status, halted_on_illegal);
    next_cycle();
    end_test("halt and illegal stop");
  endtask

  initial begin
    reset            = 1'b1;
    dispatch_valid   = '0;
    dispatch_dest    = '0;
    dispatch_halt    = '0;
    dispatch_illegal = '0;
    complete_valid   = '0;
    complete_rob_idx = '0;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    timed_out        = 1'b0;
    run_tests();
    end_run();
  end

endmodule
